// File: src/mm_defs.svh
// --------------------
// sizes of the matrix engine
// and of the shared memory bus
// --------------------
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// matrix dimension, square tiles only
`define MM_N 4
// A and B element width
`define MM_EW 8
// C element width, equal to the memory word
`define MM_ACC_W 32
// word address width of the shared memory
`define MEM_AW 8
// bus masters behind the arbiter
`define MEM_NMST 4

`endif

// File: src/mem_bus_pkg.sv
// --------------------
// memory bus request and response
// structs, bus master indices
// --------------------
`default_nettype none

`include "mm_defs.svh"

package mem_bus_pkg;

    typedef struct packed {
        logic                 valid;
        logic                 we;
        logic [`MEM_AW-1:0]   addr;
        logic [`MM_ACC_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 rvalid;
        logic [`MM_ACC_W-1:0] rdata;
    } mem_rsp_t;

    // also the arbiter port index
    typedef enum logic [1:0] {
        MST_HOST,
        MST_LOAD_A,
        MST_LOAD_B,
        MST_DMA
    } master_e;

endpackage

`default_nettype wire

// File: src/mm_pkg.sv
// --------------------
// operand tile and result types,
// FSM state enums
// --------------------
`default_nettype none

`include "mm_defs.svh"

package mm_pkg;

    typedef logic signed [`MM_EW-1:0]    elem_t;
    typedef logic signed [`MM_ACC_W-1:0] acc_t;

    // row r is one memory word, element j sits in byte j
    typedef elem_t [`MM_N-1:0][`MM_N-1:0] tile_t;
    typedef acc_t  [`MM_N-1:0][`MM_N-1:0] result_t;

    typedef enum logic [2:0] {IDLE, LOAD, COMPUTE, STORE, FINISH} dma_state_e;

    typedef enum logic [1:0] {LD_IDLE, LD_REQ, LD_DONE} ld_state_e;

    typedef enum logic [1:0] {MM_IDLE, MM_ACC, MM_DONE} mm_state_e;

endpackage

`default_nettype wire

// File: src/shared_mem.sv
// --------------------
// single-port word RAM,
// one-cycle read latency
// --------------------
`default_nettype none

`include "mm_defs.svh"

module shared_mem
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  mem_req_t req_i,
    output mem_rsp_t rsp_o
);

    logic [`MM_ACC_W-1:0] mem [2**`MEM_AW];

    always_ff @(posedge clk) begin
        if (req_i.valid && req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
        end
        rsp_o.rdata  <= mem[req_i.addr];
        // only reads produce a response
        rsp_o.rvalid <= req_i.valid && !req_i.we;
    end

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
// --------------------
// round-robin arbiter of four masters
// onto the shared memory, read steering
// --------------------
`default_nettype none

`include "mm_defs.svh"

module mem_arbiter
    import mem_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  mem_req_t             req_i [`MEM_NMST],
    output logic [`MEM_NMST-1:0] gnt_o,
    output mem_rsp_t             rsp_o [`MEM_NMST],
    output mem_req_t             mem_req_o,
    input  mem_rsp_t             mem_rsp_i
);

    master_e last_q;
    master_e owner_q;
    master_e win;
    logic    found;
    logic    rd_q;

    // search starts one past the last winner
    always_comb begin
        logic [1:0] cand;
        found = 1'b0;
        win   = last_q;
        for (int off = 1; off <= `MEM_NMST; off++) begin
            cand = last_q + 2'(off);
            if (!found && req_i[cand].valid) begin
                found = 1'b1;
                win   = master_e'(cand);
            end
        end
    end

    always_comb begin
        gnt_o = '0;
        if (found) begin
            gnt_o[win] = 1'b1;
        end
    end

    assign mem_req_o = found ? req_i[win] : '0;

    // read owner for the response one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q  <= MST_DMA;
            owner_q <= MST_HOST;
            rd_q    <= 1'b0;
        end else begin
            rd_q <= found && !req_i[win].we;
            if (found) begin
                last_q  <= win;
                owner_q <= win;
            end
        end
    end

    always_comb begin
        for (int m = 0; m < `MEM_NMST; m++) begin
            rsp_o[m].rvalid = rd_q && mem_rsp_i.rvalid && (owner_q == master_e'(m));
            rsp_o[m].rdata  = mem_rsp_i.rdata;
        end
    end

endmodule

`default_nettype wire

// File: src/matrix_loader.sv
// --------------------
// reads four rows from memory
// into an operand tile
// --------------------
`default_nettype none

`include "mm_defs.svh"

module matrix_loader
    import mem_bus_pkg::*;
    import mm_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ld_start_i,
    input  logic [`MEM_AW-1:0] base_i,
    output mem_req_t           req_o,
    input  logic               gnt_i,
    input  mem_rsp_t           rsp_i,
    output tile_t              tile_o,
    output logic               ld_done_o
);

    ld_state_e  state_q;
    logic [2:0] issue_q;
    logic [2:0] resp_q;
    logic [2:0] inflight;
    tile_t      tile_q;

    assign inflight = issue_q - resp_q;

    // at most two reads outstanding
    always_comb begin
        req_o.valid = (state_q == LD_REQ) && (issue_q < 3'd4) && (inflight < 3'd2);
        req_o.we    = 1'b0;
        req_o.addr  = base_i + {{(`MEM_AW-3){1'b0}}, issue_q};
        req_o.wdata = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= LD_IDLE;
            issue_q <= '0;
            resp_q  <= '0;
        end else begin
            case (state_q)
                LD_IDLE: begin
                    if (ld_start_i) begin
                        state_q <= LD_REQ;
                        issue_q <= '0;
                        resp_q  <= '0;
                    end
                end
                LD_REQ: begin
                    if (req_o.valid && gnt_i) begin
                        issue_q <= issue_q + 3'd1;
                    end
                    if (rsp_i.rvalid) begin
                        resp_q <= resp_q + 3'd1;
                        if (resp_q == 3'd3) begin
                            state_q <= LD_DONE;
                        end
                    end
                end
                default: state_q <= LD_IDLE;
            endcase
        end
    end

    // responses come back in issue order
    always_ff @(posedge clk) begin
        if (state_q == LD_REQ && rsp_i.rvalid) begin
            tile_q[resp_q[1:0]] <= rsp_i.rdata;
        end
    end

    assign tile_o    = tile_q;
    assign ld_done_o = (state_q == LD_DONE);

endmodule

`default_nettype wire

// File: src/mm_engine.sv
// --------------------
// 4x4 signed multiply-accumulate array,
// one k step per cycle
// --------------------
`default_nettype none

`include "mm_defs.svh"

module mm_engine
    import mm_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    mm_start_i,
    input  tile_t   tile_a_i,
    input  tile_t   tile_b_i,
    output result_t result_o,
    output logic    mm_done_o
);

    mm_state_e  state_q;
    logic [1:0] k_q;
    result_t    acc_q;

    // elements are signed, so products and sums extend by sign
    logic signed [2*`MM_EW-1:0] prod [`MM_N][`MM_N];

    always_comb begin
        for (int i = 0; i < `MM_N; i++) begin
            for (int j = 0; j < `MM_N; j++) begin
                prod[i][j] = tile_a_i[i][k_q] * tile_b_i[k_q][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= MM_IDLE;
            k_q     <= '0;
        end else begin
            case (state_q)
                MM_IDLE: begin
                    if (mm_start_i) begin
                        state_q <= MM_ACC;
                        k_q     <= '0;
                    end
                end
                MM_ACC: begin
                    k_q <= k_q + 2'd1;
                    if (k_q == 2'(`MM_N - 1)) begin
                        state_q <= MM_DONE;
                    end
                end
                default: state_q <= MM_IDLE;
            endcase
        end
    end

    // accumulators clear on start and hold until the next one
    always_ff @(posedge clk) begin
        if (state_q == MM_IDLE && mm_start_i) begin
            acc_q <= '0;
        end else if (state_q == MM_ACC) begin
            for (int i = 0; i < `MM_N; i++) begin
                for (int j = 0; j < `MM_N; j++) begin
                    acc_q[i][j] <= acc_q[i][j] + prod[i][j];
                end
            end
        end
    end

    assign result_o  = acc_q;
    assign mm_done_o = (state_q == MM_DONE);

endmodule

`default_nettype wire

// File: src/dma_ctrl.sv
// --------------------
// job sequencer: load A and B,
// run the engine, store C, report done
// --------------------
`default_nettype none

`include "mm_defs.svh"

module dma_ctrl
    import mem_bus_pkg::*;
    import mm_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  logic [`MEM_AW-1:0] a_addr_i,
    input  logic [`MEM_AW-1:0] b_addr_i,
    input  logic [`MEM_AW-1:0] c_addr_i,
    output logic               ld_a_start_o,
    output logic               ld_b_start_o,
    output logic [`MEM_AW-1:0] ld_a_addr_o,
    output logic [`MEM_AW-1:0] ld_b_addr_o,
    input  logic               ld_a_done_i,
    input  logic               ld_b_done_i,
    output logic               mm_start_o,
    input  logic               mm_done_i,
    input  result_t            result_i,
    output mem_req_t           req_o,
    input  logic               gnt_i,
    output logic               busy_o,
    output logic               done_o
);

    dma_state_e         state_q;
    logic [`MEM_AW-1:0] a_addr_q;
    logic [`MEM_AW-1:0] b_addr_q;
    logic [`MEM_AW-1:0] c_addr_q;
    logic               ld_start_q;
    logic               mm_start_q;
    logic               a_done_q;
    logic               b_done_q;
    logic               a_done;
    logic               b_done;
    logic [3:0]         idx_q;

    // a done pulse counts in its own cycle
    assign a_done = a_done_q || ld_a_done_i;
    assign b_done = b_done_q || ld_b_done_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            ld_start_q <= 1'b0;
            mm_start_q <= 1'b0;
            a_done_q   <= 1'b0;
            b_done_q   <= 1'b0;
            idx_q      <= '0;
        end else begin
            ld_start_q <= 1'b0;
            mm_start_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q    <= LOAD;
                        ld_start_q <= 1'b1;
                        a_done_q   <= 1'b0;
                        b_done_q   <= 1'b0;
                    end
                end
                LOAD: begin
                    a_done_q <= a_done;
                    b_done_q <= b_done;
                    if (a_done && b_done) begin
                        state_q    <= COMPUTE;
                        mm_start_q <= 1'b1;
                    end
                end
                COMPUTE: begin
                    if (mm_done_i) begin
                        state_q <= STORE;
                        idx_q   <= '0;
                    end
                end
                STORE: begin
                    if (gnt_i) begin
                        idx_q <= idx_q + 4'd1;
                        if (idx_q == 4'd15) begin
                            state_q <= FINISH;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // job addresses, taken only when a job starts
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            a_addr_q <= a_addr_i;
            b_addr_q <= b_addr_i;
            c_addr_q <= c_addr_i;
        end
    end

    // element (i,j) goes to c_addr + 4i + j
    always_comb begin
        req_o.valid = (state_q == STORE);
        req_o.we    = 1'b1;
        req_o.addr  = c_addr_q + {{(`MEM_AW-4){1'b0}}, idx_q};
        req_o.wdata = result_i[idx_q[3:2]][idx_q[1:0]];
    end

    assign ld_a_start_o = ld_start_q;
    assign ld_b_start_o = ld_start_q;
    assign ld_a_addr_o  = a_addr_q;
    assign ld_b_addr_o  = b_addr_q;
    assign mm_start_o   = mm_start_q;
    assign busy_o       = (state_q != IDLE);
    assign done_o       = (state_q == FINISH);

endmodule

`default_nettype wire

// File: src/mm_subsys_top.sv
// --------------------
// matrix-multiply subsystem top:
// memory, arbiter, loaders, engine, DMA
// --------------------
`default_nettype none

`include "mm_defs.svh"

module mm_subsys_top
    import mem_bus_pkg::*;
    import mm_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  logic [`MEM_AW-1:0] a_addr_i,
    input  logic [`MEM_AW-1:0] b_addr_i,
    input  logic [`MEM_AW-1:0] c_addr_i,
    input  mem_req_t           host_req_i,
    output logic               host_gnt_o,
    output mem_rsp_t           host_rsp_o,
    output logic               busy_o,
    output logic               done_o
);

    mem_req_t             mst_req [`MEM_NMST];
    mem_rsp_t             mst_rsp [`MEM_NMST];
    logic [`MEM_NMST-1:0] mst_gnt;
    mem_req_t             mem_req;
    mem_rsp_t             mem_rsp;

    logic               ld_a_start;
    logic               ld_b_start;
    logic [`MEM_AW-1:0] ld_a_addr;
    logic [`MEM_AW-1:0] ld_b_addr;
    logic               ld_a_done;
    logic               ld_b_done;
    tile_t              tile_a;
    tile_t              tile_b;
    logic               mm_start;
    logic               mm_done;
    result_t            result;

    // host port is master 0 on the bus
    assign mst_req[MST_HOST] = host_req_i;
    assign host_gnt_o        = mst_gnt[MST_HOST];
    assign host_rsp_o        = mst_rsp[MST_HOST];

    shared_mem u_mem (
        .clk   (clk),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

    mem_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (mst_req),
        .gnt_o     (mst_gnt),
        .rsp_o     (mst_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    matrix_loader u_load_a (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld_start_i (ld_a_start),
        .base_i     (ld_a_addr),
        .req_o      (mst_req[MST_LOAD_A]),
        .gnt_i      (mst_gnt[MST_LOAD_A]),
        .rsp_i      (mst_rsp[MST_LOAD_A]),
        .tile_o     (tile_a),
        .ld_done_o  (ld_a_done)
    );

    matrix_loader u_load_b (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld_start_i (ld_b_start),
        .base_i     (ld_b_addr),
        .req_o      (mst_req[MST_LOAD_B]),
        .gnt_i      (mst_gnt[MST_LOAD_B]),
        .rsp_i      (mst_rsp[MST_LOAD_B]),
        .tile_o     (tile_b),
        .ld_done_o  (ld_b_done)
    );

    mm_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .mm_start_i (mm_start),
        .tile_a_i   (tile_a),
        .tile_b_i   (tile_b),
        .result_o   (result),
        .mm_done_o  (mm_done)
    );

    dma_ctrl u_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .a_addr_i     (a_addr_i),
        .b_addr_i     (b_addr_i),
        .c_addr_i     (c_addr_i),
        .ld_a_start_o (ld_a_start),
        .ld_b_start_o (ld_b_start),
        .ld_a_addr_o  (ld_a_addr),
        .ld_b_addr_o  (ld_b_addr),
        .ld_a_done_i  (ld_a_done),
        .ld_b_done_i  (ld_b_done),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .result_i     (result),
        .req_o        (mst_req[MST_DMA]),
        .gnt_i        (mst_gnt[MST_DMA]),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
// --------------------
// testbench clock, 8 ns period,
// and active-low reset
// --------------------
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // held for five rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_mm_subsys.sv
// --------------------
// testbench of the matrix-multiply subsystem:
// vector jobs, host traffic during jobs, readback
// --------------------
`default_nettype none

`include "mm_defs.svh"

module tb_mm_subsys
    import mem_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int GNT_TIMEOUT   = 64;
    localparam int RSP_TIMEOUT   = 8;
    localparam int JOB_TIMEOUT   = 2000;
    localparam int TRAFFIC_LIMIT = 400;
    localparam int RESET_TIMEOUT = 20;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic [`MEM_AW-1:0] a_addr;
    logic [`MEM_AW-1:0] b_addr;
    logic [`MEM_AW-1:0] c_addr;
    mem_req_t           host_req;
    logic               host_gnt;
    mem_rsp_t           host_rsp;
    logic               busy;
    logic               done;

    logic [31:0] lfsr_state;
    int          done_count;
    string       test_name;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mm_subsys_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start),
        .a_addr_i   (a_addr),
        .b_addr_i   (b_addr),
        .c_addr_i   (c_addr),
        .host_req_i (host_req),
        .host_gnt_o (host_gnt),
        .host_rsp_o (host_rsp),
        .busy_o     (busy),
        .done_o     (done)
    );

    // done pulses, sampled like a flop would
    always @(posedge clk) begin
        if (!rst_n) begin
            done_count <= 0;
        end else if (done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input mem_rsp_t rsp,
                              input logic [`MM_ACC_W-1:0] exp_word);
        if (rsp.rdata !== exp_word) begin
            $display("FAILED %s %s: expected %08h, actual %08h",
                     test_name, what, exp_word, rsp.rdata);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %0b, actual %0b", test_name, what, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic timeout_error(input string what);
        $display("timeout in test %s while waiting for %s", test_name, what);
        stop_on_error();
    endtask

    // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < nbits; b++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // one host transfer, returns the read response for reads
    task automatic host_access(input logic we, input logic [`MEM_AW-1:0] addr,
                               input logic [`MM_ACC_W-1:0] wdata, output mem_rsp_t rsp);
        int   waited;
        logic granted;
        @(negedge clk);
        host_req.valid = 1'b1;
        host_req.we    = we;
        host_req.addr  = addr;
        host_req.wdata = wdata;
        waited  = 0;
        granted = 1'b0;
        while (!granted) begin
            // grant has settled a little after the falling edge
            #1;
            granted = host_gnt;
            @(negedge clk);
            waited++;
            if (!granted && waited > GNT_TIMEOUT) begin
                timeout_error("host grant");
            end
        end
        host_req = '0;
        rsp      = '0;
        if (!we) begin
            waited = 0;
            while (!host_rsp.rvalid) begin
                @(negedge clk);
                waited++;
                if (waited > RSP_TIMEOUT) begin
                    timeout_error("host read data");
                end
            end
            rsp = host_rsp;
        end
    endtask

    initial begin
        int                   fd;
        int                   code;
        int                   jobs;
        int                   waited;
        int                   loops;
        int                   expected_done;
        logic [8*32-1:0]      name_raw;
        logic [8*128-1:0]     line_buf;
        logic [`MEM_AW-1:0]   a_base;
        logic [`MEM_AW-1:0]   b_base;
        logic [`MEM_AW-1:0]   c_base;
        logic [`MEM_AW-1:0]   scratch;
        logic [31:0]          rnd;
        logic [31:0]          data;
        logic [`MM_ACC_W-1:0] a_words [4];
        logic [`MM_ACC_W-1:0] b_words [4];
        logic [`MM_ACC_W-1:0] c_words [16];
        mem_rsp_t             rsp;

        start         = 1'b0;
        a_addr        = '0;
        b_addr        = '0;
        c_addr        = '0;
        host_req      = '0;
        lfsr_state    = 32'hf711;
        test_name     = "reset";
        jobs          = 0;
        expected_done = 0;

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                timeout_error("reset release");
            end
        end
        @(negedge clk);
        check_flag("busy after reset", busy, 1'b0);
        check_flag("done after reset", done, 1'b0);

        fd = $fopen("dv/mm_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file dv/mm_input.txt");
            stop_on_error();
        end
        // two column description lines
        code = $fgets(line_buf, fd);
        code = $fgets(line_buf, fd);

        while (1) begin
            code = $fscanf(fd, " %s %h %h %h", name_raw, a_base, b_base, c_base);
            if (code != 4) begin
                break;
            end
            test_name = $sformatf("%0s", name_raw);
            for (int w = 0; w < 24; w++) begin
                if (w < 4) begin
                    code = $fscanf(fd, " %h", a_words[w]);
                end else if (w < 8) begin
                    code = $fscanf(fd, " %h", b_words[w-4]);
                end else begin
                    code = $fscanf(fd, " %h", c_words[w-8]);
                end
                if (code != 1) begin
                    $display("vector file is cut short in test %s", test_name);
                    stop_on_error();
                end
            end

            for (int r = 0; r < 4; r++) begin
                host_access(1'b1, a_base + 8'(r), a_words[r], rsp);
                host_access(1'b1, b_base + 8'(r), b_words[r], rsp);
            end

            @(negedge clk);
            a_addr = a_base;
            b_addr = b_base;
            c_addr = c_base;
            start  = 1'b1;
            @(negedge clk);
            start = 1'b0;
            check_flag("busy after start", busy, 1'b1);
            // repeated start while busy, must not launch a job
            @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            expected_done++;

            // scratch traffic from 0xc0 up competes with the job
            loops = 0;
            while (busy) begin
                take_bits(6, rnd);
                scratch = {2'b11, rnd[5:0]};
                take_bits(32, data);
                host_access(1'b1, scratch, data, rsp);
                host_access(1'b0, scratch, '0, rsp);
                check_word("scratch readback", rsp, data);
                loops++;
                if (loops > TRAFFIC_LIMIT) begin
                    timeout_error("end of busy");
                end
            end

            waited = 0;
            while (done_count < expected_done) begin
                @(negedge clk);
                waited++;
                if (waited > JOB_TIMEOUT) begin
                    timeout_error("done pulse");
                end
            end
            // quiet period, a second job would show up here
            repeat (8) @(negedge clk);
            check_flag("exactly one done pulse", done_count == expected_done, 1'b1);
            check_flag("busy after job", busy, 1'b0);

            for (int w = 0; w < 16; w++) begin
                host_access(1'b0, c_base + 8'(w), '0, rsp);
                check_word($sformatf("C word %0d", w), rsp, c_words[w]);
            end
            for (int r = 0; r < 4; r++) begin
                host_access(1'b0, a_base + 8'(r), '0, rsp);
                check_word($sformatf("A row %0d", r), rsp, a_words[r]);
                host_access(1'b0, b_base + 8'(r), '0, rsp);
                check_word($sformatf("B row %0d", r), rsp, b_words[r]);
            end
            jobs++;
        end
        $fclose(fd);

        if (jobs > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("the vector file held no tests");
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

// File: mm_subsys_top.f
+incdir+src
src/mem_bus_pkg.sv
src/mm_pkg.sv
src/shared_mem.sv
src/mem_arbiter.sv
src/matrix_loader.sv
src/mm_engine.sv
src/dma_ctrl.sv
src/mm_subsys_top.sv
dv/clk_gen.sv
dv/tb_mm_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the matrix-multiply testbench with Verilator and runs it
# exits with status 0 only for a clean run

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -j 0 --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mm_subsys -f mm_subsys_top.f -o tb_mm_subsys > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_mm_subsys > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "TEST FAILED" "$sim_log"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "TEST OK" "$sim_log"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// File: dv/mm_input.txt
# per test: name a_addr b_addr c_addr (hex), one line of A rows, one line of B rows (byte j = elem j)
# then the 16 expected C words in hex, row-major, four per line
identity 10 20 30
04030201 fcfdfeff f807fa05 7f009c64
00000001 00000100 00010000 01000000
00000001 00000002 00000003 00000004
ffffffff fffffffe fffffffd fffffffc
00000005 fffffffa 00000007 fffffff8
00000064 ffffff9c 00000000 0000007f
extremes 40 50 60
80808080 7f7f7f7f 7f807f80 fe02ff01
00017f80 00ff7f80 00017f80 00ff7f80
00010000 ffff0200 00000000 00000000
ffff0200 0000fc04 00000000 00000000
00000100 ffffff02 fffffe02 00000000
00000000 00000000 00000006 00000000
mixed 80 84 88
04030201 fd0200ff 01ff0100 02020202
0200ff01 fe010003 000102ff 01fe0100
00000004 00000009 fffffffd 00000002
fffffffd 00000002 00000008 fffffffb
00000004 ffffffff fffffffe ffffffff
00000006 00000004 00000000 00000002
